// File: design/lsu_consts.svh
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// Data and address width.
`define LSU_DATA_W 32

// Byte lanes per bus word.
`define LSU_LANES 4

// Byte-offset bits of an address.
`define LSU_OFS_W 2

`endif

// File: design/lsu_pkg.sv
package lsu_pkg;
  `include "lsu_consts.svh"

  typedef enum logic [1:0] {
    SZ_BYTE = 2'b00,
    SZ_HALF = 2'b01,
    SZ_WORD = 2'b10
  } lsu_size_e;

  typedef struct packed {
    logic      store;
    lsu_size_e size;
    logic      uns;   // Zero-extend on load.
  } lsu_op_t;

  typedef struct packed {
    logic [`LSU_DATA_W-1:0] addr;
    lsu_op_t                op;
    logic [`LSU_DATA_W-1:0] wdata;
  } lsu_req_t;

  typedef struct packed {
    logic [`LSU_DATA_W-1:0] addr;      // Word aligned.
    logic                   write;
    logic [`LSU_LANES-1:0]  byte_en;
    logic [`LSU_DATA_W-1:0] wdata;     // Already on its lanes.
  } lsu_bus_cmd_t;

  typedef struct packed {
    logic [`LSU_DATA_W-1:0] load_data;
    logic                   acc_err;
  } lsu_wb_t;

  typedef enum logic [1:0] {
    SPL_IDLE,
    SPL_FIRST,
    SPL_SECOND
  } split_state_e;

  typedef enum logic [1:0] {
    BUS_IDLE,
    BUS_REQ,
    BUS_DATA
  } bus_state_e;
endpackage

// File: design/lsu_agu.sv
`timescale 1ns/10ps
`include "lsu_consts.svh"

module lsu_agu import lsu_pkg::*; (
  input  logic                   forever_cpuclk,
  input  logic                   arst_n,
  input  logic                   ex_req,
  input  lsu_op_t                op,
  input  logic [`LSU_DATA_W-1:0] base,
  input  logic [`LSU_DATA_W-1:0] offset,
  input  logic [`LSU_DATA_W-1:0] wdata,
  output lsu_req_t               req,
  output logic                   accepted
);

  logic [`LSU_DATA_W-1:0] addr;

  assign addr = base + offset; // Carry out wraps.

  // Instruction record, held until the next strobe.
  always_ff @(posedge forever_cpuclk) begin
    if (ex_req) begin
      req.addr  <= addr;
      req.op    <= op;
      req.wdata <= wdata;
    end
  end

  always_ff @(posedge forever_cpuclk or negedge arst_n) begin
    if (!arst_n) begin
      accepted <= 1'b0;
    end else begin
      accepted <= ex_req; // Record valid with this pulse.
    end
  end

endmodule

// File: design/lsu_split_ctrl.sv
`timescale 1ns/10ps
`include "lsu_consts.svh"

module lsu_split_ctrl import lsu_pkg::*; (
  input  logic         forever_cpuclk,
  input  logic         arst_n,
  input  logic         accepted,
  input  lsu_req_t     req,
  input  logic         beat_done,
  input  logic         beat_err,
  output logic         beat_start,
  output logic         beat_second,
  output lsu_bus_cmd_t beat_cmd,
  output logic         busy,
  output logic         access_done,
  output logic         access_err
);

  split_state_e               state;
  split_state_e               state_nxt;
  logic [`LSU_OFS_W-1:0]      ofs;
  logic [`LSU_DATA_W-1:0]     word_addr;
  logic [`LSU_LANES-1:0]      size_mask;
  logic [2*`LSU_LANES-1:0]    lane_mask;
  logic [2*`LSU_DATA_W-1:0]   lane_data;
  logic                       crosses;
  logic                       last_beat;
  logic                       start_second;
  logic                       done_q;
  logic                       err_q;

  assign ofs       = req.addr[`LSU_OFS_W-1:0];
  assign word_addr = {req.addr[`LSU_DATA_W-1:`LSU_OFS_W], {`LSU_OFS_W{1'b0}}};

  always_comb begin
    case (req.op.size)
      SZ_BYTE: size_mask = 4'b0001;
      SZ_HALF: size_mask = 4'b0011;
      default: size_mask = 4'b1111;
    endcase
  end

  // Lanes over two words; the upper half belongs to the next word.
  assign lane_mask = {{`LSU_LANES{1'b0}}, size_mask} << ofs;
  assign lane_data = {{`LSU_DATA_W{1'b0}}, req.wdata} << {ofs, 3'b000};
  assign crosses   = |lane_mask[2*`LSU_LANES-1:`LSU_LANES];

  assign beat_second = (state == SPL_SECOND);
  assign last_beat   = beat_second || !crosses || beat_err; // Error skips beat two.
  assign beat_start  = accepted || start_second;

  always_comb begin
    beat_cmd.write = req.op.store;
    if (beat_second) begin
      beat_cmd.addr    = word_addr + `LSU_DATA_W'(`LSU_LANES);
      beat_cmd.byte_en = lane_mask[2*`LSU_LANES-1:`LSU_LANES];
      beat_cmd.wdata   = lane_data[2*`LSU_DATA_W-1:`LSU_DATA_W];
    end else begin
      beat_cmd.addr    = word_addr;
      beat_cmd.byte_en = lane_mask[`LSU_LANES-1:0];
      beat_cmd.wdata   = lane_data[`LSU_DATA_W-1:0];
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      SPL_IDLE: begin
        if (accepted) begin
          state_nxt = SPL_FIRST;
        end
      end
      SPL_FIRST: begin
        if (beat_done) begin
          state_nxt = last_beat ? SPL_IDLE : SPL_SECOND;
        end
      end
      SPL_SECOND: begin
        if (beat_done) begin
          state_nxt = SPL_IDLE;
        end
      end
      default: state_nxt = SPL_IDLE;
    endcase
  end

  always_ff @(posedge forever_cpuclk or negedge arst_n) begin
    if (!arst_n) begin
      state        <= SPL_IDLE;
      start_second <= 1'b0;
      done_q       <= 1'b0;
      err_q        <= 1'b0;
    end else begin
      state        <= state_nxt;
      start_second <= beat_done && !last_beat;
      done_q       <= beat_done && last_beat;
      if (accepted) begin
        err_q <= 1'b0;
      end else if (beat_done) begin
        err_q <= err_q | beat_err; // Sticky over both beats.
      end
    end
  end

  assign busy        = accepted || (state != SPL_IDLE) || done_q;
  assign access_done = done_q;
  assign access_err  = err_q;

endmodule

// File: design/lsu_bus_ctrl.sv
`timescale 1ns/10ps

module lsu_bus_ctrl import lsu_pkg::*; (
  input  logic         forever_cpuclk,
  input  logic         arst_n,
  input  logic         beat_start,
  input  lsu_bus_cmd_t beat_cmd,
  input  logic         bmu_lsu_grnt,
  input  logic         bmu_lsu_data_vld,
  input  logic         bmu_lsu_acc_err,
  output logic         lsu_bmu_req,
  output lsu_bus_cmd_t lsu_bmu_cmd,
  output logic         beat_done,
  output logic         beat_err
);

  bus_state_e   state;
  bus_state_e   state_nxt;
  lsu_bus_cmd_t cmd_q;

  always_comb begin
    state_nxt = state;
    case (state)
      BUS_IDLE: begin
        if (beat_start) begin
          state_nxt = BUS_REQ;
        end
      end
      BUS_REQ: begin
        if (bmu_lsu_grnt) begin
          state_nxt = BUS_DATA;
        end
      end
      BUS_DATA: begin
        if (bmu_lsu_data_vld) begin
          state_nxt = BUS_IDLE;
        end
      end
      default: state_nxt = BUS_IDLE;
    endcase
  end

  always_ff @(posedge forever_cpuclk or negedge arst_n) begin
    if (!arst_n) begin
      state <= BUS_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Command stays stable for the whole beat.
  always_ff @(posedge forever_cpuclk) begin
    if (beat_start && (state == BUS_IDLE)) begin
      cmd_q <= beat_cmd;
    end
  end

  assign lsu_bmu_req = (state == BUS_REQ);
  assign lsu_bmu_cmd = cmd_q;
  assign beat_done   = (state == BUS_DATA) && bmu_lsu_data_vld;
  assign beat_err    = beat_done && bmu_lsu_acc_err;

endmodule

// File: design/lsu_byte_lanes.sv
`timescale 1ns/10ps
`include "lsu_consts.svh"

module lsu_byte_lanes import lsu_pkg::*; (
  input  logic                   forever_cpuclk,
  input  logic                   arst_n,
  input  lsu_req_t               req,
  input  logic                   beat_done,
  input  logic                   beat_second,
  input  logic [`LSU_DATA_W-1:0] bmu_lsu_data,
  input  logic                   access_done,
  input  logic                   access_err,
  output logic                   wb_cmplt,
  output lsu_wb_t                wb
);

  logic [2*`LSU_DATA_W-1:0] merge;
  logic [2*`LSU_DATA_W-1:0] shifted;
  logic [`LSU_OFS_W-1:0]    ofs;
  logic [`LSU_DATA_W-1:0]   load_data;
  logic                     sign_b;
  logic                     sign_h;

  assign ofs = req.addr[`LSU_OFS_W-1:0];

  // Two words side by side, lower address in the low half.
  always_ff @(posedge forever_cpuclk) begin
    if (beat_done) begin
      if (beat_second) begin
        merge[2*`LSU_DATA_W-1:`LSU_DATA_W] <= bmu_lsu_data;
      end else begin
        merge[`LSU_DATA_W-1:0] <= bmu_lsu_data;
      end
    end
  end

  assign shifted = merge >> {ofs, 3'b000}; // Lowest byte to lane 0.
  assign sign_b  = !req.op.uns && shifted[7];
  assign sign_h  = !req.op.uns && shifted[15];

  always_comb begin
    case (req.op.size)
      SZ_BYTE: load_data = {{(`LSU_DATA_W-8){sign_b}}, shifted[7:0]};
      SZ_HALF: load_data = {{(`LSU_DATA_W-16){sign_h}}, shifted[15:0]};
      default: load_data = shifted[`LSU_DATA_W-1:0];
    endcase
    if (req.op.store) begin
      load_data = '0; // Nothing to return.
    end
  end

  always_ff @(posedge forever_cpuclk) begin
    if (access_done) begin
      wb.load_data <= load_data;
      wb.acc_err   <= access_err;
    end
  end

  always_ff @(posedge forever_cpuclk or negedge arst_n) begin
    if (!arst_n) begin
      wb_cmplt <= 1'b0;
    end else begin
      wb_cmplt <= access_done;
    end
  end

endmodule

// File: design/lsu_top.sv
`timescale 1ns/10ps
`include "lsu_consts.svh"

module lsu_top import lsu_pkg::*; (
  input  logic                   forever_cpuclk,
  input  logic                   arst_n,
  input  logic                   iu_lsu_ex_req,
  input  lsu_op_t                iu_lsu_op,
  input  logic [`LSU_DATA_W-1:0] iu_lsu_base,
  input  logic [`LSU_DATA_W-1:0] iu_lsu_offset,
  input  logic [`LSU_DATA_W-1:0] iu_lsu_wdata,
  output logic                   lsu_iu_stall,
  output logic                   lsu_iu_wb_cmplt,
  output lsu_wb_t                lsu_iu_wb,
  output logic                   lsu_bmu_req,
  output lsu_bus_cmd_t           lsu_bmu_cmd,
  input  logic                   bmu_lsu_grnt,
  input  logic                   bmu_lsu_data_vld,
  input  logic [`LSU_DATA_W-1:0] bmu_lsu_data,
  input  logic                   bmu_lsu_acc_err
);

  lsu_req_t     req;
  lsu_bus_cmd_t beat_cmd;
  logic         accepted;
  logic         beat_start;
  logic         beat_second;
  logic         beat_done;
  logic         beat_err;
  logic         access_done;
  logic         access_err;

  lsu_agu x_lsu_agu (
    .forever_cpuclk (forever_cpuclk),
    .arst_n         (arst_n),
    .ex_req         (iu_lsu_ex_req),
    .op             (iu_lsu_op),
    .base           (iu_lsu_base),
    .offset         (iu_lsu_offset),
    .wdata          (iu_lsu_wdata),
    .req            (req),
    .accepted       (accepted)
  );

  lsu_split_ctrl x_lsu_split_ctrl (
    .forever_cpuclk (forever_cpuclk),
    .arst_n         (arst_n),
    .accepted       (accepted),
    .req            (req),
    .beat_done      (beat_done),
    .beat_err       (beat_err),
    .beat_start     (beat_start),
    .beat_second    (beat_second),
    .beat_cmd       (beat_cmd),
    .busy           (lsu_iu_stall),
    .access_done    (access_done),
    .access_err     (access_err)
  );

  lsu_bus_ctrl x_lsu_bus_ctrl (
    .forever_cpuclk   (forever_cpuclk),
    .arst_n           (arst_n),
    .beat_start       (beat_start),
    .beat_cmd         (beat_cmd),
    .bmu_lsu_grnt     (bmu_lsu_grnt),
    .bmu_lsu_data_vld (bmu_lsu_data_vld),
    .bmu_lsu_acc_err  (bmu_lsu_acc_err),
    .lsu_bmu_req      (lsu_bmu_req),
    .lsu_bmu_cmd      (lsu_bmu_cmd),
    .beat_done        (beat_done),
    .beat_err         (beat_err)
  );

  lsu_byte_lanes x_lsu_byte_lanes (
    .forever_cpuclk (forever_cpuclk),
    .arst_n         (arst_n),
    .req            (req),
    .beat_done      (beat_done),
    .beat_second    (beat_second),
    .bmu_lsu_data   (bmu_lsu_data),
    .access_done    (access_done),
    .access_err     (access_err),
    .wb_cmplt       (lsu_iu_wb_cmplt),
    .wb             (lsu_iu_wb)
  );

endmodule

// File: tests/lsu_tb_clk.sv
`timescale 1ns/10ps

module lsu_tb_clk (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk    = 1'b0;
    arst_n = 1'b0;
    repeat (3) @(negedge clk);
    arst_n = 1'b1; // Released away from the rising edge.
  end

  always #10 clk = ~clk;

endmodule

// File: tests/lsu_checker.sv
`timescale 1ns/10ps

module lsu_checker import lsu_pkg::*; (
  input  logic        forever_cpuclk,
  input  logic        arst_n,
  input  logic        iu_lsu_ex_req,
  input  lsu_op_t     iu_lsu_op,
  input  logic [31:0] iu_lsu_base,
  input  logic [31:0] iu_lsu_offset,
  input  logic [31:0] iu_lsu_wdata,
  input  logic        lsu_iu_stall,
  input  logic        lsu_iu_wb_cmplt,
  input  lsu_wb_t     lsu_iu_wb,
  output int          pass_count,
  output int          fail_count
);

  logic [31:0] shadow [0:63];
  logic [31:0] exp_data;
  logic        exp_err;
  logic        exp_load;
  logic        in_flight;
  string       name;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // Little-endian bytes from the shadow, wrapping at 64 words.
  function automatic logic [31:0] ref_load(input logic [31:0] addr, input lsu_size_e size,
                                           input logic uns);
    logic [31:0] v;
    int          n;
    n = (size == SZ_BYTE) ? 1 : (size == SZ_HALF) ? 2 : 4;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v[8*k +: 8] = shadow[((addr + k) >> 2) % 64][8*((addr + k) % 4) +: 8];
    end
    if (!uns && n < 4 && v[8*n-1]) begin
      v = v | (32'hffff_ffff << (8*n));
    end
    return v;
  endfunction

  // A faulting word is not written, and a fault on the first word cancels the second.
  task automatic expect_access();
    logic [31:0] addr;
    logic [31:0] a;
    int          n;
    addr    = iu_lsu_base + iu_lsu_offset;
    n       = (iu_lsu_op.size == SZ_BYTE) ? 1 : (iu_lsu_op.size == SZ_HALF) ? 2 : 4;
    exp_err = 1'b0;
    for (int k = 0; k < n; k++) begin
      a       = addr + k;
      exp_err = exp_err | a[12];
      if (iu_lsu_op.store && !a[12] && !addr[12]) begin
        shadow[a[7:2]][8*a[1:0] +: 8] = iu_lsu_wdata[8*k +: 8];
      end
    end
    exp_data  = ref_load(addr, iu_lsu_op.size, iu_lsu_op.uns);
    exp_load  = !iu_lsu_op.store;
    in_flight = 1'b1;
    name      = $sformatf("%s of %0d bytes at 0x%08h", exp_load ? "load" : "store", n, addr);
  endtask

  task automatic check_result();
    if (!in_flight) begin
      fail_count++;
      $display("Completion pulse with no access in flight at %0t", $time);
    end else if (lsu_iu_wb.acc_err !== exp_err) begin
      fail_count++;
      $display("[FAIL] %s: expected acc_err %b, actual %b", name, exp_err, lsu_iu_wb.acc_err);
    end else if (exp_load && !exp_err && lsu_iu_wb.load_data !== exp_data) begin
      fail_count++;
      $display("[FAIL] %s: expected 0x%08h, actual 0x%08h", name, exp_data,
               lsu_iu_wb.load_data);
    end else begin
      pass_count++;
      $display("[PASS] %s", name);
    end
    in_flight = 1'b0;
  endtask

  initial begin
    logic [31:0] r;
    r          = 32'h63da;
    pass_count = 0;
    fail_count = 0;
    in_flight  = 1'b0;
    for (int i = 0; i < 64; i++) begin
      r         = xorshift32(r);
      shadow[i] = r; // Same sequence as the bus memory.
    end
  end

  // Inputs change on the falling edge, so the rising edge sees settled values.
  always @(posedge forever_cpuclk) begin
    if (arst_n) begin
      if (lsu_iu_wb_cmplt) begin
        check_result();
      end else if (lsu_iu_stall !== in_flight) begin
        fail_count++;
        $display("Stall is %b with %0s access in flight at %0t", lsu_iu_stall,
                 in_flight ? "an" : "no", $time);
      end
      if (iu_lsu_ex_req) begin
        expect_access();
      end
    end
  end

endmodule

// File: tests/lsu_tb.sv
`timescale 1ns/10ps

module lsu_tb import lsu_pkg::*; ();

  logic         forever_cpuclk;
  logic         arst_n;
  logic         iu_lsu_ex_req;
  lsu_op_t      iu_lsu_op;
  logic [31:0]  iu_lsu_base;
  logic [31:0]  iu_lsu_offset;
  logic [31:0]  iu_lsu_wdata;
  logic         lsu_iu_stall;
  logic         lsu_iu_wb_cmplt;
  lsu_wb_t      lsu_iu_wb;
  logic         lsu_bmu_req;
  lsu_bus_cmd_t lsu_bmu_cmd;
  logic         bmu_lsu_grnt;
  logic         bmu_lsu_data_vld;
  logic [31:0]  bmu_lsu_data;
  logic         bmu_lsu_acc_err;
  logic [31:0]  mem [0:63];
  logic [31:0]  rnd;
  int           pass_count;
  int           fail_count;
  int           tb_errors;

  lsu_tb_clk  i_clk (.clk(forever_cpuclk), .arst_n(arst_n));
  lsu_top     i_dut (.*);
  lsu_checker i_chk (.*);

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic logic [31:0] next_rand();
    rnd = xorshift32(rnd);
    return rnd;
  endfunction

  // One beat with random grant and data delays; bit 12 set means a bus error.
  task automatic serve_beat();
    lsu_bus_cmd_t cmd;
    cmd = lsu_bmu_cmd;
    repeat (next_rand() % 4) @(negedge forever_cpuclk);
    bmu_lsu_grnt = 1'b1;
    @(negedge forever_cpuclk);
    bmu_lsu_grnt = 1'b0;
    repeat (next_rand() % 4) @(negedge forever_cpuclk);
    bmu_lsu_data_vld = 1'b1;
    bmu_lsu_acc_err  = cmd.addr[12];
    bmu_lsu_data     = cmd.addr[12] ? next_rand() : mem[cmd.addr[7:2]];
    for (int i = 0; i < 4; i++) begin
      if (cmd.write && !cmd.addr[12] && cmd.byte_en[i]) begin
        mem[cmd.addr[7:2]][8*i +: 8] = cmd.wdata[8*i +: 8];
      end
    end
    @(negedge forever_cpuclk);
    bmu_lsu_data_vld = 1'b0;
  endtask

  // Strobe one instruction, then serve its beats until completion.
  task automatic access(input logic store, input lsu_size_e size, input logic uns,
                        input logic [31:0] addr, input logic [31:0] wdata);
    int cycles;
    @(negedge forever_cpuclk);
    iu_lsu_ex_req = 1'b1;
    iu_lsu_op     = '{store, size, uns};
    iu_lsu_base   = next_rand();
    iu_lsu_offset = addr - iu_lsu_base; // Random split with the same sum.
    iu_lsu_wdata  = wdata;
    @(negedge forever_cpuclk);
    iu_lsu_ex_req = 1'b0;
    cycles        = 0;
    while (!lsu_iu_wb_cmplt) begin
      if (lsu_bmu_req) begin
        serve_beat();
      end else begin
        @(negedge forever_cpuclk);
      end
      cycles++;
      if (cycles > 30) begin
        $display("Timeout waiting for completion of the access at 0x%08h", addr);
        $display("** FAIL **");
        $finish;
      end
    end
  endtask

  initial begin
    logic [31:0] r;
    int          cycles;
    iu_lsu_ex_req    = 1'b0;
    iu_lsu_op        = '0;
    iu_lsu_base      = '0;
    iu_lsu_offset    = '0;
    iu_lsu_wdata     = '0;
    bmu_lsu_grnt     = 1'b0;
    bmu_lsu_data_vld = 1'b0;
    bmu_lsu_data     = '0;
    bmu_lsu_acc_err  = 1'b0;
    tb_errors        = 0;
    rnd              = 32'h63da;
    for (int i = 0; i < 64; i++) begin
      mem[i] = next_rand();
    end
    cycles = 0;
    while (arst_n !== 1'b1) begin
      @(negedge forever_cpuclk);
      cycles++;
      if (cycles > 10) begin
        $display("Reset was never released");
        $display("** FAIL **");
        $finish;
      end
    end
    repeat (2) @(negedge forever_cpuclk);
    if (lsu_bmu_req !== 1'b0) begin
      $display("Bus request is not low after reset");
      tb_errors++;
    end
    // Aligned loads with both extensions.
    access(1'b0, SZ_WORD, 1'b0, 32'h40, 0);
    access(1'b0, SZ_HALF, 1'b0, 32'h46, 0);
    access(1'b0, SZ_HALF, 1'b1, 32'h46, 0);
    access(1'b0, SZ_BYTE, 1'b0, 32'h43, 0);
    access(1'b0, SZ_BYTE, 1'b1, 32'h43, 0);
    // Stores read back with their neighbours.
    access(1'b1, SZ_WORD, 1'b0, 32'h10, 32'h80ff_7f01);
    access(1'b0, SZ_BYTE, 1'b0, 32'h13, 0);
    access(1'b0, SZ_BYTE, 1'b1, 32'h13, 0);
    access(1'b0, SZ_HALF, 1'b0, 32'h12, 0);
    access(1'b0, SZ_HALF, 1'b1, 32'h12, 0);
    access(1'b1, SZ_BYTE, 1'b0, 32'h21, 32'ha5);
    access(1'b0, SZ_WORD, 1'b0, 32'h20, 0);
    // Word crossings including the memory wrap.
    access(1'b1, SZ_WORD, 1'b0, 32'h2e, 32'hcafe_f00d);
    access(1'b0, SZ_WORD, 1'b0, 32'h2c, 0);
    access(1'b0, SZ_WORD, 1'b0, 32'h30, 0);
    access(1'b0, SZ_HALF, 1'b0, 32'h2f, 0);
    access(1'b0, SZ_WORD, 1'b0, 32'hfd, 0);
    // Error addresses.
    access(1'b0, SZ_WORD, 1'b0, 32'h1000, 0);
    access(1'b1, SZ_WORD, 1'b0, 32'h1004, 32'h1234_5678);
    access(1'b0, SZ_WORD, 1'b0, 32'h4, 0);
    access(1'b1, SZ_HALF, 1'b0, 32'hfff, 32'hbeef); // Faults on beat two only.
    access(1'b0, SZ_WORD, 1'b0, 32'hfc, 0);
    access(1'b0, SZ_WORD, 1'b0, 32'h0, 0);
    for (int n = 0; n < 30; n++) begin
      r = next_rand();
      access(r[16], (r[18:17] == 2'd3) ? SZ_WORD : lsu_size_e'(r[18:17]), r[19],
             {19'd0, (r[15:13] == 3'd0), 4'd0, r[7:0]}, next_rand());
    end
    repeat (2) @(negedge forever_cpuclk);
    $display("Done: %0d passed, %0d failed, %0d other errors", pass_count, fail_count,
             tb_errors);
    if (fail_count == 0 && tb_errors == 0 && pass_count > 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: lsu_top.f
+incdir+design
design/lsu_pkg.sv
design/lsu_agu.sv
design/lsu_split_ctrl.sv
design/lsu_bus_ctrl.sv
design/lsu_byte_lanes.sv
design/lsu_top.sv
tests/lsu_tb_clk.sv
tests/lsu_checker.sv
tests/lsu_tb.sv
